//--- design/stepper_pkg.sv
package stepper_pkg;

  // Widths
  localparam int PHASE_W    = 3;   // Coil table index over 8 entries
  localparam int STEP_CNT_W = 16;  // Steps per move
  localparam int PERIOD_W   = 16;  // Clock cycles between step pulses
  localparam int DAC_W      = 8;   // PWM resolution of a 256-cycle frame

  // Smaller step period requests are clamped up to this
  localparam logic [PERIOD_W-1:0] MIN_PERIOD = 2;

  // Step resolution
  // Encoding 3 is reserved and walks nowhere
  typedef enum logic [1:0] {
    FULL    = 2'd0,  // Increment 4
    HALF    = 2'd1,  // Increment 2
    QUARTER = 2'd2   // Increment 1
  } microstep_e;

  // Step generator FSM
  typedef enum logic [1:0] {
    IDLE      = 2'd0,  // Waiting for a move command
    WAIT_TICK = 2'd1,  // Counting down the step period
    STEP      = 2'd2   // Step pulse high this cycle
  } gen_state_e;

  // Coil patterns in bit order {b2, b1, a2, a1}
  // Even entries drive both coils and odd entries one
  localparam logic [3:0] PHASE_TABLE [0:7] = '{
    4'b1010,
    4'b0010,
    4'b0110,
    4'b0100,
    4'b0101,
    4'b0001,
    4'b1001,
    4'b1000
  };

  // Table increment per step is four shifted right by the mode
  function automatic logic [PHASE_W-1:0] step_incr(input microstep_e mode);
    logic [3:0] shifted;
    shifted = 4'd4 >> mode;  // Mode 3 shifts to zero
    return shifted[PHASE_W-1:0];
  endfunction

endpackage

//--- design/step_if.sv
`timescale 1ns/10ps

// Step and direction link from step generator to phase sequencer
interface step_if;

  logic                   step;    // One-cycle pulse per step
  logic                   dir;     // 1 walks the table upward
  logic                   enable;  // Bridge drive enable, level
  stepper_pkg::microstep_e mode;   // Step resolution

  // Generator side
  modport gen (
    output step,
    output dir
  );

  // Sequencer side, always accepts a pulse
  modport seq (
    input step,
    input dir,
    input enable,
    input mode
  );

endinterface

//--- design/pwm_dac.sv
`timescale 1ns/10ps

// Frame-latched PWM for one coil reference voltage
// Output averages to duty/256 once a frame has passed
module pwm_dac (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [stepper_pkg::DAC_W-1:0] duty,
  output logic                          pwm
);

  logic [stepper_pkg::DAC_W-1:0] frame_cnt;  // Free-running 0..255
  logic [stepper_pkg::DAC_W-1:0] duty_q;     // Duty for current frame
  logic                          pwm_q;

  // Frame counter wraps naturally at 2**DAC_W
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      frame_cnt <= '0;
    end else begin
      frame_cnt <= frame_cnt + 1'b1;
    end
  end

  // Duty only changes at the frame boundary
  // so a mid-frame update never chops a pulse
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      duty_q <= '0;
    end else if (frame_cnt == '0) begin
      duty_q <= duty;
    end
  end

  // Registered compare keeps the pin glitch-free
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pwm_q <= 1'b0;
    end else begin
      pwm_q <= (frame_cnt < duty_q);  // Duty 0 never high, 255 low once per frame
    end
  end

  assign pwm = pwm_q;

endmodule

//--- design/step_pulse_gen.sv
`timescale 1ns/10ps

// Move command to timed step pulses
// One pulse every period cycles and done one cycle after the last
module step_pulse_gen (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               cmd_start,
  input  logic                               cmd_dir,
  input  logic [stepper_pkg::STEP_CNT_W-1:0] cmd_steps,
  input  logic [stepper_pkg::PERIOD_W-1:0]   cmd_period,
  output logic                               busy,
  output logic                               done,
  step_if.gen                                gen
);

  stepper_pkg::gen_state_e state;

  logic [stepper_pkg::STEP_CNT_W-1:0] steps_left;  // Pulses still to send
  logic [stepper_pkg::PERIOD_W-1:0]   tick_cnt;    // Wait countdown
  logic [stepper_pkg::PERIOD_W-1:0]   reload;      // Period minus two
  logic [stepper_pkg::PERIOD_W-1:0]   eff_period;  // Clamped request
  logic                               busy_q;
  logic                               done_q;
  logic                               step_q;
  logic                               dir_q;

  // Clamp period to the minimum
  assign eff_period = (cmd_period < stepper_pkg::MIN_PERIOD) ?
                      stepper_pkg::MIN_PERIOD : cmd_period;

  // Countdown loads period-2 since one cycle goes to the start latch or the STEP state
  // and one to the WAIT_TICK exit, which puts pulses exactly period cycles apart
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= stepper_pkg::IDLE;
      busy_q     <= 1'b0;
      done_q     <= 1'b0;
      step_q     <= 1'b0;
      dir_q      <= 1'b0;
      steps_left <= '0;
      tick_cnt   <= '0;
      reload     <= '0;
    end else begin
      done_q <= 1'b0;  // Pulses by default
      step_q <= 1'b0;
      case (state)
        stepper_pkg::IDLE: begin
          if (cmd_start) begin  // busy is low in IDLE
            dir_q    <= cmd_dir;
            reload   <= eff_period - stepper_pkg::MIN_PERIOD;
            tick_cnt <= eff_period - stepper_pkg::MIN_PERIOD;
            if (cmd_steps == '0) begin
              done_q <= 1'b1;  // Empty move gives done next cycle
            end else begin
              steps_left <= cmd_steps;
              busy_q     <= 1'b1;
              state      <= stepper_pkg::WAIT_TICK;
            end
          end
        end
        stepper_pkg::WAIT_TICK: begin
          if (tick_cnt == '0) begin
            step_q     <= 1'b1;  // High during STEP
            steps_left <= steps_left - 1'b1;
            state      <= stepper_pkg::STEP;
          end else begin
            tick_cnt <= tick_cnt - 1'b1;
          end
        end
        stepper_pkg::STEP: begin
          if (steps_left == '0) begin
            done_q <= 1'b1;  // Last pulse sent
            busy_q <= 1'b0;  // Falls with done
            state  <= stepper_pkg::IDLE;
          end else begin
            tick_cnt <= reload;
            state    <= stepper_pkg::WAIT_TICK;
          end
        end
        default: begin
          busy_q <= 1'b0;
          state  <= stepper_pkg::IDLE;
        end
      endcase
    end
  end

  assign busy     = busy_q;
  assign done     = done_q;
  assign gen.step = step_q;
  assign gen.dir  = dir_q;  // Held for the whole move

endmodule

//--- design/hbridge_sequencer.sv
`timescale 1ns/10ps

// Coil phase sequencer for a dual H-bridge
// Walks the eight-entry table by 4, 2 or 1 per step pulse
module hbridge_sequencer (
  input  logic clk,
  input  logic rst_n,
  step_if.seq  seq,
  output logic phase_a1,
  output logic phase_a2,
  output logic phase_b1,
  output logic phase_b2
);

  logic [stepper_pkg::PHASE_W-1:0] phase_idx;  // Current table position
  logic [stepper_pkg::PHASE_W-1:0] next_idx;
  logic [stepper_pkg::PHASE_W-1:0] incr_mag;   // 4, 2, 1 or 0
  logic signed [stepper_pkg::PHASE_W:0] incr_s;  // Signed step, -4..4
  logic [3:0] coil_next;
  logic [3:0] coil_q;                          // {b2, b1, a2, a1}

  // Increment from resolution and direction
  always_comb begin
    incr_mag = stepper_pkg::step_incr(seq.mode);
    if (seq.dir) begin
      incr_s = $signed({1'b0, incr_mag});   // Walk up
    end else begin
      incr_s = -$signed({1'b0, incr_mag});  // Walk down
    end
  end

  // Next index, wraps modulo 8 via truncation
  always_comb begin
    next_idx = phase_idx;
    if (seq.step) begin
      next_idx = phase_idx + incr_s[stepper_pkg::PHASE_W-1:0];
    end
  end

  // Table lookup on the new index
  // Disabled bridge floats all four inputs low
  always_comb begin
    if (seq.enable) begin
      coil_next = stepper_pkg::PHASE_TABLE[next_idx];
    end else begin
      coil_next = 4'b0000;
    end
  end

  // Index advances even while disabled, so position is never lost
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      phase_idx <= '0;
    end else begin
      phase_idx <= next_idx;
    end
  end

  // Registered bridge inputs, one cycle after the step pulse
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      coil_q <= 4'b0000;  // All bridge legs off
    end else begin
      coil_q <= coil_next;
    end
  end

  // Table bit order to bridge pins
  assign phase_a1 = coil_q[0];
  assign phase_a2 = coil_q[1];
  assign phase_b1 = coil_q[2];
  assign phase_b2 = coil_q[3];

endmodule

//--- design/stepper_driver_top.sv
`timescale 1ns/10ps

// Stepper drive block
// step generator, coil sequencer and two reference-voltage DACs
module stepper_driver_top (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               cmd_start,   // Move request strobe
  input  logic                               cmd_dir,
  input  logic [stepper_pkg::STEP_CNT_W-1:0] cmd_steps,
  input  logic [stepper_pkg::PERIOD_W-1:0]   cmd_period,  // Cycles per step
  input  logic [1:0]                         microsteps,  // microstep_e encoding
  input  logic                               enable,
  input  logic [stepper_pkg::DAC_W-1:0]      current_a,   // Phase A current setpoint
  input  logic [stepper_pkg::DAC_W-1:0]      current_b,   // Phase B current setpoint
  output logic                               phase_a1,
  output logic                               phase_a2,
  output logic                               phase_b1,
  output logic                               phase_b2,
  output logic                               vref_a,
  output logic                               vref_b,
  output logic                               busy,
  output logic                               done
);

  step_if step_bus ();

  // Levels straight from the pins
  assign step_bus.enable = enable;
  assign step_bus.mode   = stepper_pkg::microstep_e'(microsteps);

  step_pulse_gen u_step_gen (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_start  (cmd_start),
    .cmd_dir    (cmd_dir),
    .cmd_steps  (cmd_steps),
    .cmd_period (cmd_period),
    .busy       (busy),
    .done       (done),
    .gen        (step_bus.gen)
  );

  hbridge_sequencer u_seq (
    .clk      (clk),
    .rst_n    (rst_n),
    .seq      (step_bus.seq),
    .phase_a1 (phase_a1),
    .phase_a2 (phase_a2),
    .phase_b1 (phase_b1),
    .phase_b2 (phase_b2)
  );

  // Reference voltage, phase A
  pwm_dac dac_a (
    .clk   (clk),
    .rst_n (rst_n),
    .duty  (current_a),
    .pwm   (vref_a)
  );

  // Reference voltage, phase B
  pwm_dac dac_b (
    .clk   (clk),
    .rst_n (rst_n),
    .duty  (current_b),
    .pwm   (vref_b)
  );

endmodule

//--- dv/stepper_checker.sv
`timescale 1ns/10ps

// Watches the drive block pins and predicts coil phases and PWM duty
module stepper_checker (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               cmd_start,
  input  logic                               cmd_dir,
  input  logic [stepper_pkg::STEP_CNT_W-1:0] cmd_steps,
  input  logic [1:0]                         microsteps,
  input  logic                               enable,
  input  logic [stepper_pkg::DAC_W-1:0]      current_a,
  input  logic [stepper_pkg::DAC_W-1:0]      current_b,
  input  logic [3:0]                         code,      // {b2, b1, a2, a1}
  input  logic                               vref_a,
  input  logic                               vref_b,
  input  logic                               busy,
  input  logic                               done,
  input  int                                 test_num,
  input  int                                 exp_idx,   // Final index from the stim file
  input  logic                               pwm_meas,  // Opens a 256-cycle duty window
  output int                                 errors
);

  logic [3:0] prev_code;
  logic       en_q;      // Enable one sample back since the phase register lags it
  logic       active;    // Move accepted and done not yet seen
  logic       mv_en;
  int         model_idx; // Predicted table position
  int         mv_delta;  // Index step kept positive modulo 8
  int         mv_steps;
  int         changes;
  int         meas_left;
  int         hi_a;
  int         hi_b;
  int         got;

  // Inverse of the coil table gives -1 for a code not in it
  function automatic int phase_to_index(input logic [3:0] c);
    for (int i = 0; i < 8; i++) begin
      if (stepper_pkg::PHASE_TABLE[i] == c) return i;
    end
    return -1;
  endfunction

  // Four shifted by the resolution
  // Reserved encoding walks nowhere
  function automatic int mode_incr(input logic [1:0] m);
    case (stepper_pkg::microstep_e'(m))
      stepper_pkg::FULL:    return 4;
      stepper_pkg::HALF:    return 2;
      stepper_pkg::QUARTER: return 1;
      default:              return 0;
    endcase
  endfunction

  always @(posedge clk) begin
    if (!rst_n) begin
      errors    = 0;
      model_idx = 0;   // Sequencer index clears with reset
      active    = 1'b0;
      meas_left = 0;
      en_q      = 1'b0;
    end else begin
      if (active) begin
        if (busy != (mv_steps != 0 && !done)) begin  // High from the cycle after start
          errors++;
          $display("ERROR move%0d busy: expected %0d actual %0d", test_num,
                   (mv_steps != 0 && !done), busy);
        end
        if (!mv_en && code != 4'b0000) begin
          errors++;
          $display("ERROR move%0d gating: expected %b actual %b", test_num, 4'b0000, code);
        end else if (mv_en && code != prev_code) begin
          got       = phase_to_index(code);
          model_idx = (model_idx + mv_delta) % 8;  // One legal step in the commanded direction
          changes++;
          if (got != model_idx) begin
            errors++;
            $display("ERROR move%0d step %0d index: expected %0d actual %0d",
                     test_num, changes, model_idx, got);
          end
        end
        if (done) begin
          active = 1'b0;
          if (!mv_en) begin
            model_idx = (model_idx + (mv_steps % 8) * mv_delta) % 8;  // Advanced unseen
          end
          if (mv_en && changes != mv_steps) begin
            errors++;
            $display("ERROR move%0d step count: expected %0d actual %0d",
                     test_num, mv_steps, changes);
          end
          if (model_idx != exp_idx) begin
            errors++;
            $display("ERROR move%0d final index: expected %0d actual %0d",
                     test_num, exp_idx, model_idx);
          end
          if (mv_en && code != stepper_pkg::PHASE_TABLE[exp_idx[2:0]]) begin
            errors++;
            $display("ERROR move%0d final phase: expected %b actual %b",
                     test_num, stepper_pkg::PHASE_TABLE[exp_idx[2:0]], code);
          end
        end
      end else begin
        // Between moves the pins hold the current entry or zero while disabled
        if (code != (en_q ? stepper_pkg::PHASE_TABLE[model_idx] : 4'b0000)) begin
          errors++;
          $display("ERROR move%0d idle phase: expected %b actual %b", test_num,
                   en_q ? stepper_pkg::PHASE_TABLE[model_idx] : 4'b0000, code);
        end
        if (busy) begin
          errors++;
          $display("ERROR move%0d idle busy: expected %0d actual %0d", test_num, 0, busy);
        end
        if (done) begin
          errors++;
          $display("A done pulse arrived with no move in progress (move %0d)", test_num);
        end
        if (cmd_start) begin  // Start taken while no move runs
          active   = 1'b1;
          mv_en    = enable;
          mv_steps = cmd_steps;
          changes  = 0;
          mv_delta = cmd_dir ? mode_incr(microsteps) : 8 - mode_incr(microsteps);
        end
      end
      if (meas_left > 0) begin
        hi_a += vref_a;
        hi_b += vref_b;
        meas_left--;
        if (meas_left == 0 && hi_a != current_a) begin
          errors++;
          $display("ERROR move%0d vref_a duty: expected %0d actual %0d",
                   test_num, current_a, hi_a);
        end
        if (meas_left == 0 && hi_b != current_b) begin
          errors++;
          $display("ERROR move%0d vref_b duty: expected %0d actual %0d",
                   test_num, current_b, hi_b);
        end
      end
      if (pwm_meas) begin
        meas_left = 256;  // One full frame of samples
        hi_a      = 0;
        hi_b      = 0;
      end
      en_q = enable;
    end
    prev_code = code;
  end

endmodule

//--- dv/stepper_driver_sva.sv
`timescale 1ns/10ps

// Bridge safety and strobe properties on the drive block pins
module stepper_driver_sva (
  input logic clk,
  input logic rst_n,
  input logic phase_a1,
  input logic phase_a2,
  input logic phase_b1,
  input logic phase_b2,
  input logic vref_a,
  input logic vref_b,
  input logic busy,
  input logic done
);

  // No shoot-through on either bridge
  a_bridge_a: assert property (@(posedge clk) disable iff (!rst_n) !(phase_a1 && phase_a2))
    else $error("Bridge A drives both legs high");
  a_bridge_b: assert property (@(posedge clk) disable iff (!rst_n) !(phase_b1 && phase_b2))
    else $error("Bridge B drives both legs high");

  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
    else $error("done stayed high for more than one cycle");
  a_done_busy: assert property (@(posedge clk) disable iff (!rst_n) done |-> !busy)
    else $error("busy still high in the done cycle");

  // Registered outputs clear one clock into reset
  a_reset_low: assert property (@(posedge clk) !rst_n |=>
      ({phase_a1, phase_a2, phase_b1, phase_b2, vref_a, vref_b, busy, done} == 8'h00))
    else $error("An output is high during reset");

endmodule

bind stepper_driver_top stepper_driver_sva u_sva (
  .clk(clk), .rst_n(rst_n), .phase_a1(phase_a1), .phase_a2(phase_a2),
  .phase_b1(phase_b1), .phase_b2(phase_b2), .vref_a(vref_a), .vref_b(vref_b),
  .busy(busy), .done(done)
);

//--- dv/stepper_driver_tb.sv
`timescale 1ns/10ps

// Testbench for the stepper drive block, moves read from the stim file
module stepper_driver_tb;

  logic                               clk;
  logic                               rst_n;
  logic                               cmd_start;
  logic                               cmd_dir;
  logic [stepper_pkg::STEP_CNT_W-1:0] cmd_steps;
  logic [stepper_pkg::PERIOD_W-1:0]   cmd_period;
  logic [1:0]                         microsteps;
  logic                               enable;
  logic [stepper_pkg::DAC_W-1:0]      current_a;
  logic [stepper_pkg::DAC_W-1:0]      current_b;
  logic                               phase_a1, phase_a2, phase_b1, phase_b2;
  logic                               vref_a, vref_b, busy, done;
  logic                               pwm_meas;  // Tells the checker to open a duty window
  int                                 test_num;
  int                                 exp_idx;
  int                                 chk_errors;
  int                                 timeouts;
  int                                 bad_lines;
  bit                                 abort;

  stepper_driver_top dut (
    .clk(clk), .rst_n(rst_n), .cmd_start(cmd_start), .cmd_dir(cmd_dir),
    .cmd_steps(cmd_steps), .cmd_period(cmd_period), .microsteps(microsteps),
    .enable(enable), .current_a(current_a), .current_b(current_b),
    .phase_a1(phase_a1), .phase_a2(phase_a2), .phase_b1(phase_b1), .phase_b2(phase_b2),
    .vref_a(vref_a), .vref_b(vref_b), .busy(busy), .done(done)
  );

  stepper_checker chk (
    .clk(clk), .rst_n(rst_n), .cmd_start(cmd_start), .cmd_dir(cmd_dir),
    .cmd_steps(cmd_steps), .microsteps(microsteps), .enable(enable),
    .current_a(current_a), .current_b(current_b),
    .code({phase_b2, phase_b1, phase_a2, phase_a1}),
    .vref_a(vref_a), .vref_b(vref_b), .busy(busy), .done(done),
    .test_num(test_num), .exp_idx(exp_idx), .pwm_meas(pwm_meas), .errors(chk_errors)
  );

  always #5 clk = ~clk;  // 10 ns period

  // One move, then a 600-cycle hold for the PWM window
  task automatic run_move(input int num, input int dir, input int mode, input int steps,
                          input int period, input int en, input int cur_a, input int cur_b,
                          input int exp);
    int limit;
    int waited;
    bit seen_done;
    bit retrig;
    @(negedge clk);
    test_num   = num;
    exp_idx    = exp;
    cmd_dir    = dir[0];
    cmd_steps  = steps;
    cmd_period = period;
    microsteps = mode[1:0];
    enable     = en[0];
    current_a  = cur_a;
    current_b  = cur_b;
    repeat (4) @(negedge clk);  // Phase pins follow enable before the move
    cmd_start = 1'b1;
    limit     = steps * ((period < 2) ? 2 : period) + 64;
    waited    = 0;
    seen_done = 1'b0;
    retrig    = 1'b0;
    while (!seen_done && waited < limit) begin
      @(negedge clk);
      waited++;
      if (cmd_start) begin  // Strobes last one cycle
        cmd_start = 1'b0;
        cmd_dir   = dir[0];
        cmd_steps = steps;
      end
      if (done) begin
        seen_done = 1'b1;
      end else if (busy && !retrig) begin
        cmd_start = 1'b1;     // Conflicting command mid-move, must be dropped
        cmd_dir   = ~dir[0];
        cmd_steps = steps + 3;
        retrig    = 1'b1;
      end
    end
    if (!seen_done) begin
      $display("Timeout: move %0d gave no done pulse within %0d cycles", num, limit);
      timeouts++;
      abort = 1'b1;
    end else begin
      repeat (300) @(negedge clk);
      pwm_meas = 1'b1;
      @(negedge clk);
      pwm_meas = 1'b0;
      repeat (299) @(negedge clk);
    end
  endtask

  initial begin
    int fd;
    int n;
    int lines;
    bit reading;
    int f_dir, f_mode, f_steps, f_period, f_en, f_ca, f_cb, f_exp;
    clk        = 1'b0;
    rst_n      = 1'b0;
    cmd_start  = 1'b0;
    cmd_dir    = 1'b0;
    cmd_steps  = '0;
    cmd_period = '0;
    microsteps = 2'd0;
    enable     = 1'b0;
    current_a  = '0;
    current_b  = '0;
    pwm_meas   = 1'b0;
    test_num   = 0;
    exp_idx    = 0;
    timeouts   = 0;
    bad_lines  = 0;
    abort      = 1'b0;
    lines      = 0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    fd = $fopen("dv/stepper_stim.txt", "r");
    if (fd == 0) begin
      $display("The stim file dv/stepper_stim.txt could not be opened");
      bad_lines++;
    end else begin
      reading = 1'b1;
      while (reading && !abort && lines < 1000) begin  // Bounded even on a runaway file
        n = $fscanf(fd, "%d %d %d %d %d %d %d %d\n",
                    f_dir, f_mode, f_steps, f_period, f_en, f_ca, f_cb, f_exp);
        if (n == 8) begin
          lines++;
          run_move(lines, f_dir, f_mode, f_steps, f_period, f_en, f_ca, f_cb, f_exp);
        end else begin
          if (!$feof(fd)) begin
            $display("Stim file line %0d could not be read as eight numbers", lines + 1);
            bad_lines++;
          end
          reading = 1'b0;
        end
      end
      $fclose(fd);
      if (lines == 0) begin
        $display("The stim file held no moves");
        bad_lines++;
      end
    end
    repeat (2) @(negedge clk);
    $display("Summary: %0d moves, %0d checker errors, %0d timeouts, %0d stim file errors",
             lines, chk_errors, timeouts, bad_lines);
    if (chk_errors == 0 && timeouts == 0 && bad_lines == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- dv/stepper_stim.txt
1 2 5 4 1 128 64 5
0 2 3 2 1 0 255 2
1 1 3 3 1 255 0 0
0 1 5 2 1 77 200 6
1 0 3 5 1 16 240 2
0 0 2 2 1 200 33 2
1 2 0 4 1 90 90 2
1 2 3 3 0 50 100 5
0 1 1 2 0 1 254 3
1 2 2 1 1 128 128 5
0 0 0 0 1 255 255 5
0 2 7 2 1 10 20 6
1 1 4 6 1 3 252 6

//--- stepper_driver_top.f
design/stepper_pkg.sv
design/step_if.sv
design/pwm_dac.sv
design/step_pulse_gen.sv
design/hbridge_sequencer.sv
design/stepper_driver_top.sv
dv/stepper_checker.sv
dv/stepper_driver_sva.sv
dv/stepper_driver_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module stepper_driver_tb -f stepper_driver_top.f -o sim_stepper

./obj_dir/sim_stepper > sim.log 2>&1 || true
cat sim.log

if grep -qx "ALL CHECKS PASSED" sim.log; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed, see sim.log"
exit 1
